// File: Bender.yml
package:
  name: logic_analyzer

sources:
  - rtl/la_pkg.sv
  - rtl/sample_sync.sv
  - rtl/capture_ctrl.sv
  - rtl/sample_ram.sv
  - rtl/uart_tx.sv
  - rtl/logic_analyzer.sv
  - target: simulation
    files:
      - dv/tb_logic_analyzer.sv

// File: dv/tb_logic_analyzer.sv
// testbench for the logic analyzer: row table, uart frame decoder, compare tasks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_logic_analyzer import la_pkg::*; ();

  localparam int DEPTH        = 5;
  localparam int CLKS_PER_BIT = 4;
  localparam int CLK_NS       = 8;
  localparam int NROWS        = 7;

  typedef struct packed {
    div_t        div;
    logic [5:0]  dly;
    logic [15:0] rd;
    logic        send_cfg;  // SET_DIV and SET_CNT before the run
    logic        mid_cmd;   // RUN plus next row's SET_CNT during readback
  } row_t;

  logic      clk_i;
  logic      rst_in;
  sample_t   probe_i;
  logic      cmd_stb_i;
  host_cmd_t cmd_i;
  logic      uart_tx_o;
  logic      busy_o;

  row_t    rows [NROWS];
  sample_t rx_bytes [$];   // decoded frames, newest sample first
  int      rx_count;
  sample_t last_probe;     // probe value in the strobe cycle of the last command
  int      cur_row;
  int      rows_done;
  int      checks_done;
  int      error_count;

  logic_analyzer #(
    .DEPTH        (DEPTH),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) dut_i (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .probe_i   (probe_i),
    .cmd_stb_i (cmd_stb_i),
    .cmd_i     (cmd_i),
    .uart_tx_o (uart_tx_o),
    .busy_o    (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  // counter probe, random start, steps every clock
  initial begin
    void'($urandom(32'hfd13));
    probe_i = sample_t'($urandom);
    forever begin
      @(negedge clk_i);
      probe_i <= probe_i + 1'b1;
    end
  end

  task automatic check_sample(sample_t got, sample_t exp, string what);
    checks_done++;
    if (got !== exp) begin
      $display("Fail %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_count(int got, int exp, string what);
    checks_done++;
    if (got != exp) begin
      $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_level(logic got, logic exp, string what);
    checks_done++;
    if (got !== exp) begin
      $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_range(int got, int lo, int hi, string what);
    checks_done++;
    if (got < lo || got > hi) begin
      $display("Fail %0t: %s got %0d expected %0d..%0d", $time, what, got, lo, hi);
      error_count++;
    end
  endtask

  function automatic row_t make_row(int div, int dly, int rd, logic cfg, logic mid);
    row_t r;
    r.div      = div_t'(div);
    r.dly      = 6'(dly);
    r.rd       = 16'(rd);
    r.send_cfg = cfg;
    r.mid_cmd  = mid;
    return r;
  endfunction

  function automatic host_cmd_t div_cmd(div_t div);
    host_cmd_t c;
    c                 = '0;
    c.op              = SET_DIV;
    c.payload.div.div = div;
    return c;
  endfunction

  function automatic host_cmd_t cnt_cmd(logic [5:0] dly, logic [15:0] rd);
    host_cmd_t c;
    c                     = '0;
    c.op                  = SET_CNT;
    c.payload.cnt.dly_cnt = dly;
    c.payload.cnt.rd_cnt  = rd;
    return c;
  endfunction

  function automatic host_cmd_t run_cmd();
    host_cmd_t c;
    c    = '0;
    c.op = RUN;
    return c;
  endfunction

  // fill wait, capture, then one frame plus handshake per byte, with slack
  function automatic int row_time_ns(row_t r);
    int per;
    int cyc;
    per = int'(r.div) + 1;
    cyc = 4 * int'(r.rd) * per + 8;
    cyc += (4 * int'(r.dly) + 1) * per + 10;
    cyc += 4 * int'(r.rd) * (10 * CLKS_PER_BIT + 4) + 100;
    return cyc * CLK_NS;
  endfunction

  task automatic load_table();
    rows[0] = make_row(0, 1, 1, 1'b0, 1'b0);  // reset defaults only
    rows[1] = make_row(0, 2, 3, 1'b1, 1'b0);
    rows[2] = make_row(2, 1, 2, 1'b1, 1'b0);
    rows[3] = make_row(5, 3, 8, 1'b1, 1'b0);  // whole memory
    rows[4] = make_row(1, 2, 4, 1'b1, 1'b1);
    rows[5] = make_row(1, 1, 2, 1'b0, 1'b0);  // counts from row 4 readback
    rows[6] = make_row(3, 4, 5, 1'b1, 1'b0);
  endtask

  task automatic watchdog(int limit_ns);
    #(limit_ns);
    $display("watchdog timeout after %0d ns: row %0d never finished", limit_ns, cur_row);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic send_cmd(host_cmd_t c);
    @(negedge clk_i);
    cmd_i     = c;
    cmd_stb_i = 1'b1;
    #1;
    last_probe = probe_i;  // counter already stepped on this edge
    @(negedge clk_i);
    cmd_stb_i = 1'b0;
    cmd_i     = '0;
  endtask

  // entered half a clock into the start bit, samples near each bit centre
  task automatic receive_byte(output sample_t b);
    int i;
    b = '0;
    repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
    if (uart_tx_o !== 1'b0) begin
      $display("start bit at %0t went high before its middle", $time);
      error_count++;
    end
    for (i = 0; i < SAMPLE_W; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk_i);
      b[i] = uart_tx_o;  // lsb first
    end
    repeat (CLKS_PER_BIT) @(negedge clk_i);
    if (uart_tx_o !== 1'b1) begin
      $display("stop bit at %0t was low, the frame is broken", $time);
      error_count++;
    end
  endtask

  task automatic collect_frames();
    sample_t b;
    logic    done;
    rx_bytes.delete();
    rx_count = 0;
    done     = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      if (!busy_o) begin
        done = 1'b1;  // drops after the last stop bit
      end else if (uart_tx_o === 1'b0) begin
        receive_byte(b);
        rx_bytes.push_back(b);
        rx_count++;
      end
    end
  endtask

  // commands during readback, RUN must be ignored
  task automatic inject_cmds(row_t nxt_row);
    wait (rx_count > 0);
    check_level(busy_o, 1'b1, "busy before mid-readback commands");
    send_cmd(run_cmd());
    send_cmd(cnt_cmd(nxt_row.dly, nxt_row.rd));
  endtask

  task automatic run_row(int idx);
    row_t    r;
    sample_t run_probe;
    int      errs_before;
    int      lo;
    int      depth;
    int      i;
    r           = rows[idx];
    cur_row     = idx;
    errs_before = error_count;
    check_level(busy_o, 1'b0, "busy before run");
    check_level(uart_tx_o, 1'b1, "line idle before run");
    if (r.send_cfg) begin
      send_cmd(div_cmd(r.div));
      send_cmd(cnt_cmd(r.dly, r.rd));
    end
    // pre-trigger history at the current rate
    repeat (4 * int'(r.rd) * (int'(r.div) + 1) + 8) @(negedge clk_i);
    send_cmd(run_cmd());
    run_probe = last_probe;
    check_level(busy_o, 1'b1, "busy after run");
    rx_count = 0;  // mid-readback commands wait on this row's first byte
    fork
      collect_frames();
      if (r.mid_cmd) inject_cmds(rows[idx + 1]);
    join
    check_count(rx_bytes.size(), 4 * int'(r.rd), "bytes returned");
    for (i = 1; i < rx_bytes.size(); i++) begin
      check_sample(rx_bytes[i], rx_bytes[i-1] - sample_t'(int'(r.div) + 1), "step between bytes");
    end
    if (rx_bytes.size() > 0) begin
      // newest is 4*dly-1 periods past the first post-run strobe, two cycles of sync lag
      lo    = 4 * int'(r.dly) * (int'(r.div) + 1) - int'(r.div) - 3;
      depth = int'(sample_t'(rx_bytes[0] - run_probe));
      check_range(depth, lo, lo + int'(r.div), "post-trigger depth");
    end
    check_level(uart_tx_o, 1'b1, "line idle after readback");
    rows_done++;
    $display("row %0d: div %0d dly %0d rd %0d, %0d bytes, %s", idx, r.div, r.dly, r.rd,
             rx_bytes.size(), (error_count == errs_before) ? "ok" : "errors");
  endtask

  initial begin
    int limit_ns;
    int i;
    rst_in      = 1'b0;
    cmd_stb_i   = 1'b0;
    cmd_i       = '0;
    cur_row     = 0;
    rows_done   = 0;
    checks_done = 0;
    error_count = 0;
    rx_count    = 0;
    load_table();
    limit_ns = 20 * CLK_NS;  // reset and start-up
    for (i = 0; i < NROWS; i++) begin
      limit_ns += row_time_ns(rows[i]);
    end
    fork
      watchdog(limit_ns);
    join_none
    repeat (2) @(negedge clk_i);
    rst_in = 1'b1;
    for (i = 0; i < NROWS; i++) begin
      run_row(i);
    end
    $display("%0d of %0d rows run, %0d checks, %0d errors", rows_done, NROWS, checks_done,
             error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic_analyzer.f
rtl/la_pkg.sv
rtl/sample_sync.sv
rtl/capture_ctrl.sv
rtl/sample_ram.sv
rtl/uart_tx.sv
rtl/logic_analyzer.sv
dv/tb_logic_analyzer.sv

// File: rtl/capture_ctrl.sv
// capture and readback sequencer: sample pointer, counts, memory address and uart strobe
`timescale 1ns/1ps
`default_nettype none

module capture_ctrl import la_pkg::*; #(
  parameter int DEPTH = 5         // address width
) (
  input  logic             clk_i,
  input  logic             rst_in,
  input  logic             cmd_stb_i,  // single cycle, no back-pressure
  input  host_cmd_t        cmd_i,
  input  logic             smp_stb_i,  // new sample available
  output logic             mem_we_o,
  output logic [DEPTH-1:0] mem_addr_o,
  input  logic             tx_rdy_i,
  output logic             tx_stb_o,   // one stage after address
  output logic             busy_o
);

  localparam int CNT_W = 18;  // 16 bit count times 4

  typedef enum logic [1:0] { IDLE, TRG, TX, TX_WAIT } state_e;

  state_e           state;
  state_e           state_next;
  logic [5:0]       dly_cnt;
  logic [15:0]      rd_cnt;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_next;
  logic [CNT_W-1:0] tgt;        // latched target of current phase
  logic [CNT_W-1:0] tgt_next;
  logic [DEPTH-1:0] ptr;
  logic [DEPTH-1:0] ptr_next;
  logic             tx_req;     // address out this cycle
  logic             tx_stb_q;
  logic             run;
  logic             set_cnt;

  assign run     = cmd_stb_i && (cmd_i.op == RUN);
  assign set_cnt = cmd_stb_i && (cmd_i.op == SET_CNT);

  always_comb begin
    state_next = state;
    cnt_next   = cnt;
    tgt_next   = tgt;
    ptr_next   = ptr;
    mem_we_o   = 1'b0;
    tx_req     = 1'b0;
    case (state)
      // free running capture, keeps the pre-trigger history
      IDLE: begin
        if (smp_stb_i) begin
          mem_we_o = 1'b1;
          ptr_next = ptr + 1'b1;  // wraps at 2**DEPTH
        end
        if (run) begin
          state_next = TRG;
          cnt_next   = '0;
          tgt_next   = {{(CNT_W-8){1'b0}}, dly_cnt, 2'b00};
        end
      end
      TRG: begin
        if (cnt == tgt) begin
          state_next = TX;
          cnt_next   = '0;
          tgt_next   = {rd_cnt, 2'b00};
          ptr_next   = ptr - 1'b1;  // back to newest sample
        end else if (smp_stb_i) begin
          mem_we_o = 1'b1;
          cnt_next = cnt + 1'b1;
          ptr_next = ptr + 1'b1;
        end
      end
      // newest first, one byte per uart frame
      TX: begin
        if (cnt == tgt) begin
          state_next = IDLE;
        end else if (tx_rdy_i) begin
          tx_req     = 1'b1;
          state_next = TX_WAIT;
          cnt_next   = cnt + 1'b1;
          ptr_next   = ptr - 1'b1;
        end
      end
      TX_WAIT: begin
        if (tx_rdy_i) begin  // low while strobe in flight
          state_next = TX;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state    <= IDLE;
      cnt      <= '0;
      tgt      <= '0;
      ptr      <= '0;
      tx_stb_q <= 1'b0;
    end else begin
      state    <= state_next;
      cnt      <= cnt_next;
      tgt      <= tgt_next;
      ptr      <= ptr_next;
      tx_stb_q <= tx_req;  // lines up with ram rdata
    end
  end

  // counts from host, picked up at the next phase start
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      dly_cnt <= 6'd1;
      rd_cnt  <= 16'd1;
    end else if (set_cnt) begin
      dly_cnt <= cmd_i.payload.cnt.dly_cnt;
      rd_cnt  <= cmd_i.payload.cnt.rd_cnt;
    end
  end

  assign mem_addr_o = ptr;
  assign tx_stb_o   = tx_stb_q;
  assign busy_o     = (state != IDLE);

  // writes only while capturing, never with a byte in flight to the uart
  a_we_capture: assert property (@(posedge clk_i) disable iff (!rst_in)
    mem_we_o |-> (state inside {IDLE, TRG}) && !tx_stb_q);

  // strobe was issued in a cycle where the uart reported ready
  a_stb_rdy: assert property (@(posedge clk_i) disable iff (!rst_in)
    tx_stb_o |-> $past(tx_rdy_i));

endmodule

`default_nettype wire

// File: rtl/la_pkg.sv
// logic analyzer package: sample type, command opcodes, payload union, host command struct
`default_nettype none

package la_pkg;

  localparam int SAMPLE_W = 8;  // probe width, also one uart byte

  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [15:0]         div_t;     // sample period minus one

  // host opcodes, top two bits of the command word
  typedef enum logic [1:0] {
    NOP     = 2'd0,
    SET_CNT = 2'd1,
    RUN     = 2'd2,
    SET_DIV = 2'd3
  } cmd_op_e;

  typedef struct packed {
    logic [5:0]  dly_cnt;   // post-trigger samples / 4
    logic [7:0]  reserved;
    logic [15:0] rd_cnt;    // readback samples / 4
  } cnt_payload_t;

  typedef struct packed {
    logic [13:0] reserved;
    div_t        div;       // clocks per sample - 1
  } div_payload_t;

  // same 30 bits, decoded by opcode
  typedef union packed {
    cnt_payload_t cnt;      // under SET_CNT
    div_payload_t div;      // under SET_DIV
  } cmd_payload_u;

  typedef struct packed {
    cmd_op_e      op;
    cmd_payload_u payload;
  } host_cmd_t;

endpackage

`default_nettype wire

// File: rtl/logic_analyzer.sv
// logic analyzer top: sampler, sequencer, sample memory and uart, with divider command decode
`timescale 1ns/1ps
`default_nettype none

module logic_analyzer import la_pkg::*; #(
  parameter int DEPTH        = 5,  // memory address width
  parameter int CLKS_PER_BIT = 4   // uart bit time
) (
  input  logic      clk_i,
  input  logic      rst_in,
  input  sample_t   probe_i,
  input  logic      cmd_stb_i,  // one cycle, no back-pressure
  input  host_cmd_t cmd_i,
  output logic      uart_tx_o,
  output logic      busy_o
);

  logic             div_load;
  div_t             div;
  logic             smp_stb;
  sample_t          smp_data;
  logic             mem_we;
  logic [DEPTH-1:0] mem_addr;
  sample_t          rdata;
  logic             tx_stb;
  logic             tx_rdy;

  // SET_DIV goes straight to the sampler
  assign div_load = cmd_stb_i && (cmd_i.op == SET_DIV);
  assign div      = cmd_i.payload.div.div;

  sample_sync u_sample_sync (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .probe_i    (probe_i),
    .div_load_i (div_load),
    .div_i      (div),
    .smp_stb_o  (smp_stb),
    .smp_data_o (smp_data)
  );

  // SET_CNT and RUN decoded inside
  capture_ctrl #(
    .DEPTH (DEPTH)
  ) u_capture_ctrl (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .cmd_stb_i  (cmd_stb_i),
    .cmd_i      (cmd_i),
    .smp_stb_i  (smp_stb),
    .mem_we_o   (mem_we),
    .mem_addr_o (mem_addr),
    .tx_rdy_i   (tx_rdy),
    .tx_stb_o   (tx_stb),
    .busy_o     (busy_o)
  );

  sample_ram #(
    .DEPTH (DEPTH)
  ) u_sample_ram (
    .clk_i   (clk_i),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (smp_data),
    .rdata_o (rdata)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_tx (
    .clk_i  (clk_i),
    .rst_in (rst_in),
    .stb_i  (tx_stb),  // same cycle as rdata
    .data_i (rdata),
    .rdy_o  (tx_rdy),
    .tx_o   (uart_tx_o)
  );

endmodule

`default_nettype wire

// File: rtl/sample_ram.sv
// circular sample memory, single port, sync write and registered read-first read
`timescale 1ns/1ps
`default_nettype none

module sample_ram import la_pkg::*; #(
  parameter int DEPTH = 5  // 2**DEPTH entries
) (
  input  logic             clk_i,
  input  logic             we_i,
  input  logic [DEPTH-1:0] addr_i,
  input  sample_t          wdata_i,
  output sample_t          rdata_o   // one cycle after addr_i
);

  sample_t mem [2**DEPTH];
  sample_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
    rdata_q <= mem[addr_i];  // old contents on a write cycle
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: rtl/sample_sync.sv
// probe synchronizer and sample strobe generator with programmable period
`timescale 1ns/1ps
`default_nettype none

module sample_sync import la_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_in,       // sync, active low
  input  sample_t probe_i,      // async probe bus
  input  logic    div_load_i,   // new divider strobe
  input  div_t    div_i,
  output logic    smp_stb_o,    // one cycle per period
  output sample_t smp_data_o    // valid with smp_stb_o
);

  sample_t sync_q1;
  sample_t sync_q2;
  div_t    div_q;     // stored period - 1
  div_t    per_cnt;   // counts down to zero
  logic    stb_q;
  sample_t data_q;

  // two flop synchronizer
  always_ff @(posedge clk_i) begin
    sync_q1 <= probe_i;
    sync_q2 <= sync_q1;
  end

  // divider register
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      div_q <= '0;  // every clock after reset
    end else if (div_load_i) begin
      div_q <= div_i;
    end
  end

  // period counter and strobe
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      per_cnt <= '0;
      stb_q   <= 1'b0;
    end else if (div_load_i) begin
      per_cnt <= div_i;  // restart period with new value
      stb_q   <= 1'b0;
    end else if (per_cnt == '0) begin
      per_cnt <= div_q;  // reload
      stb_q   <= 1'b1;
    end else begin
      per_cnt <= per_cnt - 1'b1;
      stb_q   <= 1'b0;
    end
  end

  // sample register, captured with the strobe
  always_ff @(posedge clk_i) begin
    if (rst_in && !div_load_i && per_cnt == '0) begin
      data_q <= sync_q2;
    end
  end

  assign smp_stb_o  = stb_q;
  assign smp_data_o = data_q;

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
// 8N1 uart serializer with ready flag
`timescale 1ns/1ps
`default_nettype none

module uart_tx import la_pkg::*; #(
  parameter int CLKS_PER_BIT = 4  // bit time in clocks
) (
  input  logic    clk_i,
  input  logic    rst_in,
  input  logic    stb_i,    // start a frame
  input  sample_t data_i,   // byte to send, valid with stb_i
  output logic    rdy_o,    // idle and not taking a strobe
  output logic    tx_o      // serial line, idle high
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);

  logic              busy;
  logic              tx_q;
  logic [SAMPLE_W:0] shreg;    // stop bit above the data
  logic [3:0]        bit_cnt;  // bits left after current one
  logic [CW-1:0]     clk_cnt;

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      busy    <= 1'b0;
      tx_q    <= 1'b1;  // line idle
      bit_cnt <= '0;
      clk_cnt <= '0;
    end else if (!busy) begin
      if (stb_i) begin
        busy    <= 1'b1;
        tx_q    <= 1'b0;  // start bit
        bit_cnt <= 4'd9;
        clk_cnt <= CW'(CLKS_PER_BIT - 1);
      end
    end else if (clk_cnt != '0) begin
      clk_cnt <= clk_cnt - 1'b1;  // hold current bit
    end else if (bit_cnt == '0) begin
      busy <= 1'b0;  // stop bit done
    end else begin
      tx_q    <= shreg[0];  // lsb first, stop bit last
      bit_cnt <= bit_cnt - 1'b1;
      clk_cnt <= CW'(CLKS_PER_BIT - 1);
    end
  end

  // payload shifter
  always_ff @(posedge clk_i) begin
    if (!busy && stb_i) begin
      shreg <= {1'b1, data_i};
    end else if (busy && clk_cnt == '0 && bit_cnt != '0) begin
      shreg <= {1'b1, shreg[SAMPLE_W:1]};
    end
  end

  assign rdy_o = !busy && !stb_i;  // strobe this cycle is not ready
  assign tx_o  = tx_q;

  // sender must wait for ready before the next byte
  a_no_stb_busy: assert property (@(posedge clk_i) disable iff (!rst_in)
    stb_i |-> !busy);

endmodule

`default_nettype wire
